// ==== hw/exAlu_settings.svh ====
`ifndef EXALU_SETTINGS_SVH
`define EXALU_SETTINGS_SVH

// ##########################################################################
// execute cluster sizing
// ##########################################################################

// number of lanes in one issue bundle.
`define EX_LANES 2

// data width of every lane.
`define EX_XLEN 64

// in 64-bit mode an operand is narrow when bits 63 down to this one agree.
`define EX_NARROW_MSB 30

`endif

// ==== hw/exAluPkg.sv ====
package exAluPkg;

	// major command of an issued operation.
	typedef enum logic [5:0]
	{
		UCMD_NOP  = 6'h00,
		UCMD_ALU3 = 6'h05
	} exUCmd;

	// low four bits of the extended opcode.
	typedef enum logic [3:0]
	{
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_SHL = 4'd2,
		OP_SHR = 4'd3,
		OP_SAR = 4'd4,
		OP_AND = 4'd5,
		OP_OR  = 4'd6,
		OP_XOR = 4'd7
	} exAluOp;

	// extended opcode bits 5:4, selecting how a result is widened.
	typedef enum logic [1:0]
	{
		MODE_SX  = 2'd0,
		MODE_ZX  = 2'd1,
		MODE_Q64 = 2'd2,
		MODE_RSV = 2'd3
	} exAluMode;

	typedef enum logic [1:0]
	{
		SLOW_IDLE  = 2'd0,
		SLOW_SHIFT = 2'd1,
		SLOW_DONE  = 2'd2
	} exSlowState;

endpackage

// ==== hw/exOpDecode.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exOpDecode
	import exAluPkg::*;
#(
	parameter int lanes = 2
)
(
	input  logic                            clock,
	input  logic                            arstN,
	input  logic                            issueValid,
	input  exUCmd    [lanes-1:0]            issueCmd,
	input  logic     [lanes-1:0][5:0]       issueIxt,
	input  logic     [lanes-1:0][`EX_XLEN-1:0] issueRs,
	input  logic     [lanes-1:0][`EX_XLEN-1:0] issueRt,
	input  logic                            retireValid,
	output logic                            bundleValid,
	output logic     [lanes-1:0]            laneValid,
	output exAluOp   [lanes-1:0]            laneOp,
	output exAluMode [lanes-1:0]            laneMode,
	output logic     [lanes-1:0][`EX_XLEN-1:0] laneRs,
	output logic     [lanes-1:0][`EX_XLEN-1:0] laneRt
);

	logic inFlight;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			bundleValid <= 1'b0;
			laneValid <= '0;
			inFlight <= 1'b0;
		end
		else
		begin
			bundleValid <= issueValid;
			for (int i = 0; i < lanes; i++)
				laneValid[i] <= issueValid && (issueCmd[i] == UCMD_ALU3);
			// a new bundle may arrive in the same cycle the old one retires.
			if (issueValid)
				inFlight <= 1'b1;
			else if (retireValid)
				inFlight <= 1'b0;
		end
	end

	// the operands stay put until the next issue, so the merge stage can
	// read them for every slow lane of the bundle.
	always_ff @(posedge clock)
	begin
		if (issueValid)
		begin
			for (int i = 0; i < lanes; i++)
			begin
				laneOp[i] <= exAluOp'(issueIxt[i][3:0]);
				laneMode[i] <= exAluMode'(issueIxt[i][5:4]);
				laneRs[i] <= issueRs[i];
				laneRt[i] <= issueRt[i];
			end
		end
	end

	issueWhileBusy: assert property (@(posedge clock) disable iff (!arstN)
		issueValid |-> (!inFlight || retireValid))
		else $error("issue bundle arrived while the previous one is in flight");

endmodule

// ==== hw/exFastAlu.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exFastAlu
	import exAluPkg::*;
(
	input  logic                laneValid,
	input  exAluOp              op,
	input  exAluMode            mode,
	input  logic [`EX_XLEN-1:0] rs,
	input  logic [`EX_XLEN-1:0] rt,
	output logic [`EX_XLEN-1:0] fastVal,
	output logic                fastOk
);

	logic                isSub;
	logic [31:0]         rtEff;
	logic [16:0]         loSum0;
	logic [16:0]         loSum1;
	logic [16:0]         hiSum0;
	logic [16:0]         hiSum1;
	logic [16:0]         loSum;
	logic [16:0]         hiSum;
	logic [31:0]         sum32;
	logic                sumBit32;
	logic                rsNarrow;
	logic                rtNarrow;
	logic [`EX_XLEN-1:0] addVal;
	logic                addOk;
	logic                accept;

	// ##########################################################################
	// 32-bit adder built from two carry-select halves
	// ##########################################################################

	assign isSub = (op == OP_SUB);
	assign rtEff = isSub ? ~rt[31:0] : rt[31:0];

	assign loSum0 = {1'b0, rs[15:0]} + {1'b0, rtEff[15:0]};
	assign loSum1 = {1'b0, rs[15:0]} + {1'b0, rtEff[15:0]} + 17'd1;
	assign hiSum0 = {1'b0, rs[31:16]} + {1'b0, rtEff[31:16]};
	assign hiSum1 = {1'b0, rs[31:16]} + {1'b0, rtEff[31:16]} + 17'd1;

	// subtract is rs plus the inverted rt with a carry into the low half.
	assign loSum = isSub ? loSum1 : loSum0;
	assign hiSum = loSum[16] ? hiSum1 : hiSum0;
	assign sum32 = {hiSum[15:0], loSum[15:0]};

	// bit 32 of the sum of the two sign-extended 32-bit operands.
	assign sumBit32 = rs[31] ^ rtEff[31] ^ hiSum[16];

	assign rsNarrow = (&rs[`EX_XLEN-1:`EX_NARROW_MSB]) || !(|rs[`EX_XLEN-1:`EX_NARROW_MSB]);
	assign rtNarrow = (&rt[`EX_XLEN-1:`EX_NARROW_MSB]) || !(|rt[`EX_XLEN-1:`EX_NARROW_MSB]);

	always_comb
	begin
		case (mode)
			MODE_SX:
			begin
				addVal = {{32{sum32[31]}}, sum32};
				addOk = 1'b1;
			end
			MODE_ZX:
			begin
				addVal = {32'h0, sum32};
				addOk = 1'b1;
			end
			MODE_Q64:
			begin
				// narrow operands cannot carry past bit 32.
				addVal = {{32{sumBit32}}, sum32};
				addOk = rsNarrow && rtNarrow;
			end
			default:
			begin
				addVal = {{32{sumBit32}}, sum32};
				addOk = 1'b0;
			end
		endcase
	end

	// ##########################################################################
	// result select
	// ##########################################################################

	always_comb
	begin
		fastVal = '0;
		accept = 1'b0;
		case (op)
			OP_ADD, OP_SUB:
			begin
				fastVal = addVal;
				accept = addOk;
			end
			OP_AND:
			begin
				fastVal = rs & rt;
				accept = 1'b1;
			end
			OP_OR:
			begin
				fastVal = rs | rt;
				accept = 1'b1;
			end
			OP_XOR:
			begin
				fastVal = rs ^ rt;
				accept = 1'b1;
			end
			default:
				accept = 1'b0;
		endcase
	end

	assign fastOk = laneValid && accept;

	// an accepted Q64 sum must fit in 32 signed bits.
	always_comb
	begin
		if (fastOk && (mode == MODE_Q64) && (op == OP_ADD || op == OP_SUB))
			assert (sumBit32 == sum32[31]) else $error("narrow q64 sum carried past bit 32");
	end

endmodule

// ==== hw/exSlowAlu.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exSlowAlu
	import exAluPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                slowStart,
	input  exAluOp              op,
	input  exAluMode            mode,
	input  logic [`EX_XLEN-1:0] rs,
	input  logic [`EX_XLEN-1:0] rt,
	output logic                slowDone,
	output logic [`EX_XLEN-1:0] slowVal
);

	exSlowState          state;
	exAluOp              opReg;
	exAluMode            modeReg;
	logic [`EX_XLEN-1:0] acc;
	logic [5:0]          count;
	logic                startShift;
	logic [`EX_XLEN-1:0] startVal;
	logic [`EX_XLEN-1:0] shifted;
	logic [`EX_XLEN-1:0] extended;

	assign startShift = (op == OP_SHL) || (op == OP_SHR) || (op == OP_SAR);

	always_comb
	begin
		case (op)
			OP_ADD: startVal = rs + rt;
			OP_SUB: startVal = rs - rt;
			OP_AND: startVal = rs & rt;
			OP_OR: startVal = rs | rt;
			OP_XOR: startVal = rs ^ rt;
			OP_SHL, OP_SHR, OP_SAR: startVal = rs;
			default: startVal = '0;
		endcase
	end

	always_comb
	begin
		case (opReg)
			OP_SHL: shifted = {acc[`EX_XLEN-2:0], 1'b0};
			OP_SHR: shifted = {1'b0, acc[`EX_XLEN-1:1]};
			OP_SAR: shifted = {acc[`EX_XLEN-1], acc[`EX_XLEN-1:1]};
			default: shifted = acc;
		endcase
	end

	// the reserved mode widens like Q64.
	always_comb
	begin
		case (modeReg)
			MODE_SX: extended = {{32{acc[31]}}, acc[31:0]};
			MODE_ZX: extended = {32'h0, acc[31:0]};
			default: extended = acc;
		endcase
	end

	// ##########################################################################
	// FSM, one shift step per cycle
	// ##########################################################################

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= SLOW_IDLE;
			count <= '0;
			slowDone <= 1'b0;
		end
		else
		begin
			slowDone <= 1'b0;
			case (state)
				SLOW_IDLE:
				begin
					if (slowStart)
					begin
						count <= rt[5:0];
						// a zero shift skips the shift state entirely.
						if (startShift && (rt[5:0] != 6'd0))
							state <= SLOW_SHIFT;
						else
							state <= SLOW_DONE;
					end
				end
				SLOW_SHIFT:
				begin
					count <= count - 6'd1;
					if (count == 6'd1)
						state <= SLOW_DONE;
				end
				SLOW_DONE:
				begin
					slowDone <= 1'b1;
					state <= SLOW_IDLE;
				end
				default:
					state <= SLOW_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		case (state)
			SLOW_IDLE:
			begin
				if (slowStart)
				begin
					opReg <= op;
					modeReg <= mode;
					acc <= startVal;
				end
			end
			SLOW_SHIFT:
				acc <= shifted;
			SLOW_DONE:
				slowVal <= extended;
			default:
				acc <= acc;
		endcase
	end

	startWhileBusy: assert property (@(posedge clock) disable iff (!arstN)
		slowStart |-> (state == SLOW_IDLE))
		else $error("slowStart arrived while the slow ALU was busy");

endmodule

// ==== hw/exResultMerge.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exResultMerge
	import exAluPkg::*;
#(
	parameter int lanes = 2
)
(
	input  logic                               clock,
	input  logic                               arstN,
	input  logic                               bundleValid,
	input  logic     [lanes-1:0]               laneValid,
	input  exAluOp   [lanes-1:0]               laneOp,
	input  exAluMode [lanes-1:0]               laneMode,
	input  logic     [lanes-1:0][`EX_XLEN-1:0] laneRs,
	input  logic     [lanes-1:0][`EX_XLEN-1:0] laneRt,
	input  logic     [lanes-1:0][`EX_XLEN-1:0] fastVal,
	input  logic     [lanes-1:0]               fastOk,
	input  logic                               slowDone,
	input  logic     [`EX_XLEN-1:0]            slowVal,
	output logic                               slowStart,
	output exAluOp                             slowOp,
	output exAluMode                           slowMode,
	output logic     [`EX_XLEN-1:0]            slowRs,
	output logic     [`EX_XLEN-1:0]            slowRt,
	output logic                               retireValid,
	output logic     [lanes-1:0][`EX_XLEN-1:0] retireVal,
	output logic                               busy
);

	localparam int idxW = (lanes > 1) ? $clog2(lanes) : 1;

	logic [lanes-1:0] pending;
	logic [lanes-1:0] doneMask;
	logic [lanes-1:0] workMask;
	logic [idxW-1:0]  slowLane;
	logic [idxW-1:0]  nextLane;

	assign doneMask = slowDone ? (lanes'(1) << slowLane) : '0;
	assign workMask = bundleValid ? (laneValid & ~fastOk) : (pending & ~doneMask);

	// lowest pending lane goes first.
	always_comb
	begin
		nextLane = '0;
		for (int i = lanes - 1; i >= 0; i--)
		begin
			if (workMask[i])
				nextLane = idxW'(i);
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pending <= '0;
			slowLane <= '0;
			slowStart <= 1'b0;
			retireValid <= 1'b0;
		end
		else
		begin
			slowStart <= 1'b0;
			retireValid <= 1'b0;
			if (bundleValid || slowDone)
			begin
				pending <= workMask;
				if (|workMask)
				begin
					slowStart <= 1'b1;
					slowLane <= nextLane;
				end
				else
					retireValid <= 1'b1;
			end
		end
	end

	// lanes still pending are zeroed here and filled in by slowDone later.
	always_ff @(posedge clock)
	begin
		if (bundleValid)
		begin
			for (int i = 0; i < lanes; i++)
				retireVal[i] <= (laneValid[i] && fastOk[i]) ? fastVal[i] : '0;
		end
		else if (slowDone)
			retireVal[slowLane] <= slowVal;
	end

	assign slowOp = laneOp[slowLane];
	assign slowMode = laneMode[slowLane];
	assign slowRs = laneRs[slowLane];
	assign slowRt = laneRt[slowLane];

	assign busy = bundleValid || (|pending);

	strayDone: assert property (@(posedge clock) disable iff (!arstN)
		slowDone |-> pending[slowLane])
		else $error("slowDone arrived with no slow lane outstanding");

endmodule

// ==== hw/exAluCluster.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exAluCluster
	import exAluPkg::*;
(
	input  logic                                   clock,
	input  logic                                   arstN,
	input  logic                                   issueValid,
	input  exUCmd    [`EX_LANES-1:0]               issueCmd,
	input  logic     [`EX_LANES-1:0][5:0]          issueIxt,
	input  logic     [`EX_LANES-1:0][`EX_XLEN-1:0] issueRs,
	input  logic     [`EX_LANES-1:0][`EX_XLEN-1:0] issueRt,
	output logic                                   busy,
	output logic                                   retireValid,
	output logic     [`EX_LANES-1:0][`EX_XLEN-1:0] retireVal
);

	logic                                   bundleValid;
	logic     [`EX_LANES-1:0]               laneValid;
	exAluOp   [`EX_LANES-1:0]               laneOp;
	exAluMode [`EX_LANES-1:0]               laneMode;
	logic     [`EX_LANES-1:0][`EX_XLEN-1:0] laneRs;
	logic     [`EX_LANES-1:0][`EX_XLEN-1:0] laneRt;
	logic     [`EX_LANES-1:0][`EX_XLEN-1:0] fastVal;
	logic     [`EX_LANES-1:0]               fastOk;
	logic                                   slowStart;
	exAluOp                                 slowOp;
	exAluMode                               slowMode;
	logic     [`EX_XLEN-1:0]                slowRs;
	logic     [`EX_XLEN-1:0]                slowRt;
	logic                                   slowDone;
	logic     [`EX_XLEN-1:0]                slowVal;

	exOpDecode #(.lanes(`EX_LANES)) decode0
	(
		.clock(clock), .arstN(arstN), .issueValid(issueValid),
		.issueCmd(issueCmd), .issueIxt(issueIxt), .issueRs(issueRs), .issueRt(issueRt),
		.retireValid(retireValid), .bundleValid(bundleValid), .laneValid(laneValid),
		.laneOp(laneOp), .laneMode(laneMode), .laneRs(laneRs), .laneRt(laneRt)
	);

	for (genvar g = 0; g < `EX_LANES; g++)
	begin : fastLane
		exFastAlu fast0
		(
			.laneValid(laneValid[g]), .op(laneOp[g]), .mode(laneMode[g]),
			.rs(laneRs[g]), .rt(laneRt[g]), .fastVal(fastVal[g]), .fastOk(fastOk[g])
		);
	end

	exResultMerge #(.lanes(`EX_LANES)) merge0
	(
		.clock(clock), .arstN(arstN), .bundleValid(bundleValid), .laneValid(laneValid),
		.laneOp(laneOp), .laneMode(laneMode), .laneRs(laneRs), .laneRt(laneRt),
		.fastVal(fastVal), .fastOk(fastOk), .slowDone(slowDone), .slowVal(slowVal),
		.slowStart(slowStart), .slowOp(slowOp), .slowMode(slowMode),
		.slowRs(slowRs), .slowRt(slowRt), .retireValid(retireValid),
		.retireVal(retireVal), .busy(busy)
	);

	exSlowAlu slow0
	(
		.clock(clock), .arstN(arstN), .slowStart(slowStart), .op(slowOp),
		.mode(slowMode), .rs(slowRs), .rt(slowRt), .slowDone(slowDone), .slowVal(slowVal)
	);

endmodule

// ==== dv/exAluClusterTb.sv ====
`timescale 1ns/1ns
`include "exAlu_settings.svh"

module exAluClusterTb
	import exAluPkg::*;
();

	localparam int laneCount = `EX_LANES;
	localparam int driveDelay = 1;
	localparam int retireTimeout = 400;
	localparam int busyTimeout = 50;

	logic                                   clock;
	logic                                   arstN;
	logic                                   issueValid;
	exUCmd    [laneCount-1:0]               issueCmd;
	logic     [laneCount-1:0][5:0]          issueIxt;
	logic     [laneCount-1:0][`EX_XLEN-1:0] issueRs;
	logic     [laneCount-1:0][`EX_XLEN-1:0] issueRt;
	logic                                   busy;
	logic                                   retireValid;
	logic     [laneCount-1:0][`EX_XLEN-1:0] retireVal;

	// staged bundle, copied onto the DUT inputs at issue time.
	exUCmd       laneCmd [laneCount];
	logic [5:0]  laneIxt [laneCount];
	logic [63:0] laneRs [laneCount];
	logic [63:0] laneRt [laneCount];

	int errors = 0;
	int timeouts = 0;
	int seed = 76099;

	exAluCluster dut0
	(
		.clock(clock), .arstN(arstN), .issueValid(issueValid), .issueCmd(issueCmd),
		.issueIxt(issueIxt), .issueRs(issueRs), .issueRt(issueRt), .busy(busy),
		.retireValid(retireValid), .retireVal(retireVal)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ##########################################################################
	// reference model
	// ##########################################################################

	function automatic logic [63:0] modelResult(input exUCmd cmd, input logic [5:0] ixt,
		input logic [63:0] a, input logic [63:0] b);
		logic [63:0] full;
		logic [5:0]  amt;
		full = '0;
		amt = b[5:0];
		if (cmd != UCMD_ALU3)
			return '0;
		case (ixt[3:0])
			OP_ADD: full = a + b;
			OP_SUB: full = a - b;
			OP_SHL: full = a << amt;
			OP_SHR: full = a >> amt;
			OP_SAR: full = $signed(a) >>> amt;
			// logic operations always cover all 64 bits.
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			default: return '0;
		endcase
		case (ixt[5:4])
			MODE_SX: return {{32{full[31]}}, full[31:0]};
			MODE_ZX: return {32'h0, full[31:0]};
			default: return full;
		endcase
	endfunction

	task automatic setLane(input int lane, input exUCmd cmd, input exAluOp op,
		input exAluMode mode, input logic [63:0] a, input logic [63:0] b);
		if (lane < laneCount)
		begin
			laneCmd[lane] = cmd;
			laneIxt[lane] = {mode, op};
			laneRs[lane] = a;
			laneRt[lane] = b;
		end
	endtask

	task automatic issueAndCheck(input string name, input bit checkLatency);
		int          cycles;
		bit          seen;
		logic [63:0] expVal;
		if (timeouts != 0)
			return;
		@(posedge clock);
		#driveDelay;
		issueValid = 1'b1;
		for (int i = 0; i < laneCount; i++)
		begin
			issueCmd[i] = laneCmd[i];
			issueIxt[i] = laneIxt[i];
			issueRs[i] = laneRs[i];
			issueRt[i] = laneRt[i];
		end
		@(posedge clock);
		#driveDelay;
		issueValid = 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < retireTimeout)
		begin
			@(negedge clock);
			cycles++;
			if (retireValid)
				seen = 1'b1;
			else
			begin
				assert (busy === 1'b1) else
				begin
					$display("** Error at %0t: busy expected 1, got %b", $time, busy);
					errors++;
				end
			end
		end
		if (!seen)
		begin
			$display("Timed out waiting for the bundle to retire in %s.", name);
			timeouts++;
			return;
		end
		if (checkLatency)
		begin
			assert (cycles == 2) else
			begin
				$display("** Error at %0t: retireValid cycles expected 2, got %0d",
					$time, cycles);
				errors++;
			end
		end
		for (int i = 0; i < laneCount; i++)
		begin
			expVal = modelResult(laneCmd[i], laneIxt[i], laneRs[i], laneRt[i]);
			assert (retireVal[i] === expVal) else
			begin
				$display("** Error at %0t: retireVal[%0d] expected %h, got %h",
					$time, i, expVal, retireVal[i]);
				errors++;
			end
		end
		cycles = 0;
		while (busy !== 1'b0 && cycles < busyTimeout)
		begin
			@(negedge clock);
			cycles++;
		end
		if (busy !== 1'b0)
		begin
			$display("Timed out waiting for busy to drop after %s.", name);
			timeouts++;
		end
	endtask

	// ##########################################################################
	// directed tests
	// ##########################################################################

	task automatic testIdleAndForeign();
		@(negedge clock);
		assert (busy === 1'b0 && retireValid === 1'b0) else
		begin
			$display("** Error at %0t: busy/retireValid expected 0/0, got %b/%b",
				$time, busy, retireValid);
			errors++;
		end
		setLane(0, UCMD_NOP, OP_ADD, MODE_SX, 64'h1111, 64'h2222);
		setLane(1, exUCmd'(6'h12), OP_XOR, MODE_Q64, 64'hFFFF_0000, 64'h00FF);
		issueAndCheck("foreign commands", 1'b1);
	endtask

	task automatic testFastAddSub();
		setLane(0, UCMD_ALU3, OP_ADD, MODE_SX, 64'h0000_0000_7FFF_FFFF, 64'h1);
		setLane(1, UCMD_ALU3, OP_ADD, MODE_ZX, 64'h0000_0000_0000_FFFF, 64'h1);
		issueAndCheck("fast add", 1'b1);
		setLane(0, UCMD_ALU3, OP_SUB, MODE_SX, 64'hDEAD_BEEF_0000_0000, 64'h1);
		setLane(1, UCMD_ALU3, OP_SUB, MODE_ZX, 64'hDEAD_BEEF_0001_0000, 64'h1);
		issueAndCheck("fast subtract", 1'b1);
		setLane(0, UCMD_ALU3, OP_ADD, MODE_ZX, 64'hFFFF_FFFF, 64'hFFFF_FFFF);
		setLane(1, UCMD_ALU3, OP_SUB, MODE_SX, 64'h8000_0000, 64'h1);
		issueAndCheck("fast overflow", 1'b1);
	endtask

	task automatic testLogic();
		setLane(0, UCMD_ALU3, OP_AND, MODE_SX, 64'hF0F0_1234_FFFF_0000, 64'hFF00_FFFF_0F0F_FFFF);
		setLane(1, UCMD_ALU3, OP_OR, MODE_ZX, 64'h8000_0000_0000_0001, 64'h0123_4567_89AB_CDEF);
		issueAndCheck("and/or", 1'b1);
		setLane(0, UCMD_ALU3, OP_XOR, MODE_Q64, 64'hAAAA_5555_AAAA_5555, 64'hFFFF_FFFF_0000_0000);
		setLane(1, UCMD_ALU3, OP_XOR, MODE_RSV, 64'h8000_0000_8000_0000, 64'h1);
		issueAndCheck("xor", 1'b1);
	endtask

	task automatic testQ64();
		setLane(0, UCMD_ALU3, OP_ADD, MODE_Q64, 64'h3FFF_FFFF, 64'h3FFF_FFFF);
		setLane(1, UCMD_ALU3, OP_SUB, MODE_Q64, 64'hFFFF_FFFF_C000_0000, 64'h3FFF_FFFF);
		issueAndCheck("narrow q64", 1'b1);
		setLane(0, UCMD_ALU3, OP_ADD, MODE_Q64, 64'h0000_0001_0000_0000, 64'h5);
		setLane(1, UCMD_ALU3, OP_SUB, MODE_Q64, 64'h8000_0000_0000_0000, 64'h1);
		issueAndCheck("wide q64", 1'b0);
		setLane(0, UCMD_ALU3, OP_ADD, MODE_Q64, 64'h1234, 64'hFFFF_FFFF_FFFF_FFFE);
		setLane(1, UCMD_ALU3, OP_ADD, MODE_Q64, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1);
		issueAndCheck("mixed q64", 1'b0);
	endtask

	task automatic testShifts();
		exAluOp   shiftOps [3] = '{OP_SHL, OP_SHR, OP_SAR};
		int       amounts [3] = '{0, 1, 63};
		exAluMode mode;
		for (int o = 0; o < 3; o++)
		begin
			for (int m = 0; m < 3; m++)
			begin
				mode = exAluMode'(m);
				for (int k = 0; k < 3; k++)
				begin
					// upper bits of rt must not affect the amount.
					setLane(0, UCMD_ALU3, shiftOps[o], mode, 64'h8000_0000_8000_0001,
						{16'hA5A5, 42'h0, 6'(amounts[k])});
					setLane(1, UCMD_ALU3, shiftOps[o], mode, 64'h0123_4567_89AB_CDEF,
						{16'h5A5A, 42'h0, 6'(amounts[k])});
					issueAndCheck("shift", 1'b0);
				end
			end
		end
	endtask

	task automatic testRandom();
		logic [31:0] r;
		logic [31:0] n;
		logic [63:0] a;
		logic [63:0] b;
		exUCmd       cmd;
		for (int k = 0; k < 40; k++)
		begin
			for (int i = 0; i < laneCount; i++)
			begin
				r = $random(seed);
				a = {$random(seed), $random(seed)};
				b = {$random(seed), $random(seed)};
				// every third bundle keeps both operands inside the narrow range.
				if (k % 3 == 0)
				begin
					n = $random(seed);
					a = {{33{n[30]}}, n[30:0]};
					n = $random(seed);
					b = {{33{n[30]}}, n[30:0]};
				end
				case (r[10:8])
					3'd0: cmd = UCMD_NOP;
					3'd1: cmd = exUCmd'(6'h3F);
					default: cmd = UCMD_ALU3;
				endcase
				setLane(i, cmd, exAluOp'({1'b0, r[2:0]}), exAluMode'(r[5:4]), a, b);
			end
			issueAndCheck("random bundle", 1'b0);
		end
	endtask

	initial
	begin
		arstN = 1'b0;
		issueValid = 1'b0;
		for (int i = 0; i < laneCount; i++)
		begin
			issueCmd[i] = UCMD_NOP;
			issueIxt[i] = '0;
			issueRs[i] = '0;
			issueRt[i] = '0;
		end
		repeat (2) @(posedge clock);
		#driveDelay;
		arstN = 1'b1;
		testIdleAndForeign();
		testFastAddSub();
		testLogic();
		testQ64();
		testShifts();
		testRandom();
		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== exAluCluster.f ====
+incdir+hw
hw/exAluPkg.sv
hw/exOpDecode.sv
hw/exFastAlu.sv
hw/exSlowAlu.sv
hw/exResultMerge.sv
hw/exAluCluster.sv
dv/exAluClusterTb.sv

// ==== Makefile ====
# Verilator build for the integer execute cluster.

VERILATOR  ?= verilator
TOP        ?= exAluClusterTb
FILELIST   ?= exAluCluster.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Errors found
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
